//--- files.f
src/regfile_pkg.sv
src/lvt_control.sv
src/bank_ram.sv
src/read_port_mux.sv
src/regfile_2w6r.sv
sim/regfile_tb.sv

//--- sim/regfile_input.txt
# wr0 wa0 we0 wd0 wr1 wa1 we1 wd1 ra0 ra1 ra2 ra3 ra4 ra5, all hex, one line per cycle
# wa and ra are {context[1:0], index[4:0]}, we has one bit per lane with bit 8 the tag lane
1 01 1ff 10123456789abcdef 1 07 1ff 0fedcba9876543210 00 20 40 60 01 07
1 02 1ff 01111222233334444 1 21 1ff 15555666677778888 00 20 01 07 02 21
1 03 1ff 1999aaaabbbbcccc0 1 2a 1ff 0ddddeeeeffff0001 01 02 07 21 03 2a
1 04 1ff 00123012301230123 1 45 1ff 14567456745674567 03 2a 04 45 00 01
1 05 1ff 189ab89ab89ab89ab 1 5f 1ff 0cdefcdefcdefcdef 05 5f 04 45 20 60
1 06 1ff 10f0f0f0f0f0f0f0f 1 7f 1ff 0f0f0f0f0f0f0f0f0 06 7f 05 5f 02 03
1 07 1ff 0a5a5a5a5a5a5a5a5 1 01 1ff 15a5a5a5a5a5a5a5a 07 01 06 7f 00 40
1 21 1ff 13c3c3c3c3c3c3c3c 1 02 1ff 0c3c3c3c3c3c3c3c3 21 02 07 01 2a 45
1 2a 1ff 00011223344556677 1 03 1ff 18899aabbccddeeff 2a 03 21 02 5f 7f
1 45 1ff 1deadbeefcafef00d 1 04 1ff 00badc0ffee123456 45 04 2a 03 01 02
1 5f 1ff 07654321076543210 1 05 1ff 1fedcba98fedcba98 5f 05 45 04 06 07
1 7f 1ff 12468ace13579bdf0 1 06 1ff 0135792468ace0246 7f 06 5f 05 21 2a
0 00 000 0 0 00 000 0 01 02 03 04 05 06
0 00 000 0 0 00 000 0 07 21 2a 45 5f 7f
0 00 000 0 0 00 000 0 01 01 01 01 01 01
0 00 000 0 0 00 000 0 7f 7f 7f 7f 7f 7f
1 13 1ff 1cafe0000beef1234 0 00 000 0 00 00 00 00 00 00
0 00 000 0 0 00 000 0 13 13 13 13 13 13
0 00 000 0 0 00 000 0 13 13 13 01 02 03
1 13 101 00000000000000055 0 00 000 0 13 13 00 20 01 02
0 00 000 0 0 00 000 0 13 13 13 13 13 13
1 04 0aa 1112233445566aabb 0 00 000 0 04 04 04 00 00 00
0 00 000 0 1 04 150 1f0e1d2c3b4a59687 04 04 04 04 04 04
0 00 000 0 0 00 000 0 04 04 04 04 04 04
0 00 000 0 1 2a 100 10000000000000000 2a 2a 2a 2a 2a 2a
0 00 000 0 0 00 000 0 2a 2a 2a 04 04 04
1 45 00f 0000000001111aaaa 0 00 000 0 00 00 00 00 00 00
0 00 000 0 1 45 0f0 0aaaabbbb00000000 45 45 45 45 45 45
1 45 13c 1cccccccccccccccc 0 00 000 0 45 45 45 45 45 45
0 00 000 0 0 00 000 0 45 45 45 45 45 45
0 00 000 0 0 00 000 0 45 04 2a 13 7f 01
1 5f 1ff 11111111111111111 1 5f 0f0 02222222222222222 5f 5f 5f 5f 5f 5f
0 00 000 0 0 00 000 0 5f 5f 5f 5f 5f 5f
1 06 01f 0aaaaaaaaaaaaaaaa 1 06 1f8 1bbbbbbbbbbbbbbbb 06 06 06 00 06 06
0 00 000 0 0 00 000 0 06 06 06 06 06 06
1 07 0f0 13333444455556666 1 21 00f 07777888899990000 07 21 07 21 01 02
0 00 000 0 0 00 000 0 07 21 07 21 07 21
1 03 003 00000000000001234 0 00 000 0 03 03 03 03 03 03
1 03 00c 00000000056780000 0 00 000 0 03 03 03 03 03 03
0 00 000 0 1 03 003 0000000000000abcd 03 03 03 03 03 03
0 00 000 0 0 00 000 0 03 03 03 03 03 03
1 00 1ff 1ffffffffffffffff 1 20 1ff 1ffffffffffffffff 00 20 40 60 00 20
1 40 1ff 1ffffffffffffffff 1 60 1ff 1ffffffffffffffff 00 20 40 60 40 60
0 00 000 0 0 00 000 0 00 20 40 60 00 00
1 01 1ff 00000000000000001 1 02 1ff 00000000000000002 01 02 03 04 05 06
1 03 055 1a5a5a5a5a5a5a5a5 1 04 0aa 05a5a5a5a5a5a5a5a 01 02 03 04 05 06
1 05 1f0 1123456789abcdef0 1 06 00f 0fedcba987654321f 03 04 05 06 07 21
1 7f 001 000000000000000ee 1 7f 002 0000000000000dd00 7f 7f 7f 7f 7f 7f
0 00 000 0 0 00 000 0 7f 5f 45 2a 21 13
1 2a 1ff 00123456789abcdef 1 45 1ff 1fedcba9876543210 2a 45 2a 45 2a 45
0 00 000 0 0 00 000 0 01 07 13 21 2a 45
0 00 000 0 0 00 000 0 5f 7f 02 03 04 05
1 21 100 10000000000000000 1 21 100 00000000000000000 21 21 21 21 21 21
0 00 000 0 0 00 000 0 21 45 21 7f 21 01
0 00 000 0 0 00 000 0 00 00 00 00 00 00

//--- sim/regfile_tb.sv
module regfile_tb
	import regfile_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period   = 40;
	localparam int reset_cycles = 10;
	localparam int max_lines    = 256;
	localparam int slack_cycles = 20;
	localparam string input_path = "sim/regfile_input.txt";

	logic       clka;
	logic       arst_n;
	write_req_t wp0;
	write_req_t wp1;
	reg_addr_t  ra_drv [num_read_ports];
	reg_data_t  rd_mon [num_read_ports];

	// stimulus as read from the data file, one entry per line
	write_req_t stim_wp0 [max_lines];
	write_req_t stim_wp1 [max_lines];
	reg_addr_t  stim_ra [max_lines][num_read_ports];
	int         num_lines;

	// reference register contents and the values due on each rd
	reg_data_t  model [num_regs];
	reg_data_t  expect_rd [num_read_ports];

	int         cycle_count;
	int         cycle_limit;

	regfile_2w6r regfile_2w6r_i (
		.clka   (clka),
		.arst_n (arst_n),
		.wp0    (wp0),
		.wp1    (wp1),
		.ra0    (ra_drv[0]),
		.ra1    (ra_drv[1]),
		.ra2    (ra_drv[2]),
		.ra3    (ra_drv[3]),
		.ra4    (ra_drv[4]),
		.ra5    (ra_drv[5]),
		.rd0    (rd_mon[0]),
		.rd1    (rd_mon[1]),
		.rd2    (rd_mon[2]),
		.rd3    (rd_mon[3]),
		.rd4    (rd_mon[4]),
		.rd5    (rd_mon[5])
	);

	// ========================================
	// helpers
	// ========================================

	task automatic fail_run(string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic load_stimulus();
		int        fd;
		int        count;
		string     text;
		logic      wr0_f;
		reg_addr_t wa0_f;
		lane_en_t  we0_f;
		reg_data_t wd0_f;
		logic      wr1_f;
		reg_addr_t wa1_f;
		lane_en_t  we1_f;
		reg_data_t wd1_f;
		reg_addr_t ra_f [num_read_ports];

		fd = $fopen(input_path, "r");
		if (fd == 0) begin
			fail_run("could not open the stimulus file");
		end
		num_lines = 0;
		while ($fgets(text, fd) != 0) begin
			count = 0;
			// lines starting with # describe the columns
			if (text.len() > 0 && text[0] != "#") begin
				count = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					wr0_f, wa0_f, we0_f, wd0_f, wr1_f, wa1_f, we1_f, wd1_f,
					ra_f[0], ra_f[1], ra_f[2], ra_f[3], ra_f[4], ra_f[5]);
			end
			if (count == 14) begin
				if (num_lines >= max_lines) begin
					fail_run("the stimulus file has more lines than the testbench holds");
				end
				stim_wp0[num_lines].wr = wr0_f;
				stim_wp0[num_lines].wa = wa0_f;
				stim_wp0[num_lines].we = we0_f;
				stim_wp0[num_lines].wd = wd0_f;
				stim_wp1[num_lines].wr = wr1_f;
				stim_wp1[num_lines].wa = wa1_f;
				stim_wp1[num_lines].we = we1_f;
				stim_wp1[num_lines].wd = wd1_f;
				for (int k = 0; k < num_read_ports; k++) begin
					stim_ra[num_lines][k] = ra_f[k];
				end
				num_lines++;
			end
		end
		$fclose(fd);
	endtask

	// a lane changes only when the strobe and its own enable are both set
	task automatic apply_write(write_req_t w);
		if (w.wr) begin
			for (int l = 0; l < 8; l++) begin
				if (w.we[l]) begin
					model[w.wa][l*8 +: 8] = w.wd[l*8 +: 8];
				end
			end
			if (w.we[8]) begin
				model[w.wa][64] = w.wd[64];
			end
		end
	endtask

	// index zero reads as zero whatever the context bits are
	function automatic reg_data_t expected_for(reg_addr_t a);
		if (a[4:0] == 5'd0) begin
			return '0;
		end
		return model[a];
	endfunction

	task automatic drive_line(int i);
		wp0 = stim_wp0[i];
		wp1 = stim_wp1[i];
		for (int k = 0; k < num_read_ports; k++) begin
			ra_drv[k] = stim_ra[i][k];
		end
	endtask

	task automatic check_port(int k);
		assert (rd_mon[k] === expect_rd[k])
		else fail_run($sformatf("mismatch rd%0d got %h expected %h",
			k, rd_mon[k], expect_rd[k]));
	endtask

	task automatic check_outputs();
		for (int k = 0; k < num_read_ports; k++) begin
			check_port(k);
		end
	endtask

	// ========================================
	// clock and timeout
	// ========================================

	initial begin
		clka = 1'b0;
		forever #(clk_period / 2) clka = ~clka;
	end

	always @(posedge clka) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			fail_run($sformatf("timeout after %0d cycles with the stimulus unfinished",
				cycle_count));
		end
	end

	// ========================================
	// stimulus and checking
	// ========================================

	initial begin
		arst_n      = 1'b0;
		wp0         = '0;
		wp1         = '0;
		cycle_count = 0;
		cycle_limit = 0;
		for (int k = 0; k < num_read_ports; k++) begin
			// nonzero indexes while reset is held, so only the cleared
			// address register keeps rd at zero
			ra_drv[k]    = reg_addr_t'(k + 1);
			expect_rd[k] = '0;
		end
		for (int r = 0; r < num_regs; r++) begin
			model[r] = '0;
		end

		load_stimulus();
		if (num_lines == 0) begin
			fail_run("the stimulus file holds no usable lines");
		end
		cycle_limit = reset_cycles + num_lines + slack_cycles;

		// every rd must stay zero while reset is held
		repeat (reset_cycles) begin
			@(negedge clka);
			check_outputs();
		end
		arst_n = 1'b1;
		// the first cycle after reset reads index zero on every port
		for (int k = 0; k < num_read_ports; k++) begin
			ra_drv[k] = '0;
		end

		// each line is checked one cycle later, after its writes reach the model
		for (int i = 0; i < num_lines; i++) begin
			@(negedge clka);
			check_outputs();
			drive_line(i);
			apply_write(stim_wp0[i]);
			apply_write(stim_wp1[i]);
			for (int k = 0; k < num_read_ports; k++) begin
				expect_rd[k] = expected_for(stim_ra[i][k]);
			end
		end
		@(negedge clka);
		check_outputs();

		$display("All checks passed");
		$finish;
	end

endmodule

//--- src/bank_ram.sv
module bank_ram
	import regfile_pkg::*;
(
	input  logic       clka,
	input  write_req_t wr,
	input  reg_addr_t  ra,
	output reg_data_t  rd
);

	reg_data_t mem [num_regs];

	// ========================================
	// write side
	// ========================================

	// each lane has its own enable, the same layout the block RAM byte
	// write enables use
	always_ff @(posedge clka) begin
		if (wr.wr) begin
			for (int l = 0; l < tag_lane; l++) begin
				if (wr.we[l]) begin
					mem[wr.wa][l*byte_width +: byte_width] <=
						wr.wd[l*byte_width +: byte_width];
				end
			end
			if (wr.we[tag_lane]) begin
				mem[wr.wa][tag_bit] <= wr.wd[tag_bit];
			end
		end
	end

	// ========================================
	// read side
	// ========================================

	// read-first behaviour: an address under write returns the old word
	always_ff @(posedge clka) begin
		rd <= mem[ra];
	end

endmodule

//--- src/lvt_control.sv
module lvt_control
	import regfile_pkg::*;
(
	input  logic       clka,
	input  logic       arst_n,
	input  write_req_t wp0,
	input  write_req_t wp1,
	input  reg_addr_t  ra [num_read_ports],
	output lane_sel_t  sel [num_read_ports]
);

	// ========================================
	// live value table
	// ========================================

	// for every register and lane, the write port whose bank holds the
	// live value of that lane
	lane_sel_t owner [num_regs];

	// a lane marked here stays owned by that port until another write
	// to the same lane of the same register comes along
	always_ff @(posedge clka or negedge arst_n) begin
		if (!arst_n) begin
			// after reset every lane belongs to port 0
			for (int r = 0; r < num_regs; r++) begin
				owner[r] <= '0;
			end
		end else begin
			for (int l = 0; l < num_lanes; l++) begin
				if (wp0.wr && wp0.we[l]) begin
					owner[wp0.wa][l] <= 1'b0;
				end
				// port 1 is assigned last, so on a collision its mark wins
				if (wp1.wr && wp1.we[l]) begin
					owner[wp1.wa][l] <= 1'b1;
				end
			end
		end
	end

	// ========================================
	// lane selects per read port
	// ========================================

	// the selects come from the table as it was before this edge, which
	// is what the banks hold as well, so both arrive on the same cycle
	always_ff @(posedge clka or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < num_read_ports; k++) begin
				sel[k] <= '0;
			end
		end else begin
			for (int k = 0; k < num_read_ports; k++) begin
				sel[k] <= owner[ra[k]];
			end
		end
	end

	// writes that land on the same edge are covered by forwarding in
	// the read port mux and need no bypass here

endmodule

//--- src/read_port_mux.sv
module read_port_mux
	import regfile_pkg::*;
(
	input  logic       clka,
	input  logic       arst_n,
	input  reg_addr_t  ra,
	input  reg_data_t  bank0,
	input  reg_data_t  bank1,
	input  lane_sel_t  sel,
	input  write_req_t wp0,
	input  write_req_t wp1,
	output reg_data_t  rd
);

	reg_addr_t  ra_q;
	write_req_t wp0_q;
	write_req_t wp1_q;

	// ========================================
	// address and write capture
	// ========================================

	// these line up with the bank data, which is read on the same edge
	always_ff @(posedge clka or negedge arst_n) begin
		if (!arst_n) begin
			ra_q  <= '0;
			wp0_q <= '0;
			wp1_q <= '0;
		end else begin
			ra_q  <= ra;
			wp0_q <= wp0;
			wp1_q <= wp1;
		end
	end

	// ========================================
	// lane selection
	// ========================================

	always_comb begin
		lane_en_t  fwd0;
		lane_en_t  fwd1;
		reg_data_t fwd0_m;
		reg_data_t fwd1_m;
		reg_data_t sel_m;
		reg_data_t stored;

		// lanes written on the edge that also read the banks
		fwd0 = (wp0_q.wr && wp0_q.wa == ra_q) ? wp0_q.we : '0;
		fwd1 = (wp1_q.wr && wp1_q.wa == ra_q) ? wp1_q.we : '0;

		fwd0_m = lane_mask(fwd0);
		fwd1_m = lane_mask(fwd1);
		sel_m  = lane_mask(sel);

		// the committed value, lane by lane from whichever bank owns it
		stored = (bank1 & sel_m) | (bank0 & ~sel_m);

		// port 1 beats port 0, and both beat the stored value
		if (ra_q[idx_width-1:0] == '0) begin
			rd = '0;
		end else begin
			rd = (wp1_q.wd & fwd1_m)
				| (wp0_q.wd & fwd0_m & ~fwd1_m)
				| (stored & ~fwd0_m & ~fwd1_m);
		end
	end

endmodule

//--- src/regfile_2w6r.sv
module regfile_2w6r
	import regfile_pkg::*;
(
	input  logic       clka,
	input  logic       arst_n,
	input  write_req_t wp0,
	input  write_req_t wp1,
	input  reg_addr_t  ra0,
	input  reg_addr_t  ra1,
	input  reg_addr_t  ra2,
	input  reg_addr_t  ra3,
	input  reg_addr_t  ra4,
	input  reg_addr_t  ra5,
	output reg_data_t  rd0,
	output reg_data_t  rd1,
	output reg_data_t  rd2,
	output reg_data_t  rd3,
	output reg_data_t  rd4,
	output reg_data_t  rd5
);

	write_req_t wp_vec [num_write_ports];
	reg_addr_t  ra_vec [num_read_ports];
	lane_sel_t  sel_vec [num_read_ports];
	reg_data_t  rd_vec [num_read_ports];

	// bank output indexed by write port group, then by read port
	reg_data_t  bank_rd [num_write_ports][num_read_ports];

	assign wp_vec[0] = wp0;
	assign wp_vec[1] = wp1;

	assign ra_vec[0] = ra0;
	assign ra_vec[1] = ra1;
	assign ra_vec[2] = ra2;
	assign ra_vec[3] = ra3;
	assign ra_vec[4] = ra4;
	assign ra_vec[5] = ra5;

	assign rd0 = rd_vec[0];
	assign rd1 = rd_vec[1];
	assign rd2 = rd_vec[2];
	assign rd3 = rd_vec[3];
	assign rd4 = rd_vec[4];
	assign rd5 = rd_vec[5];

	// ========================================
	// storage banks
	// ========================================

	// one group per write port, one bank in each group per read port,
	// so every bank has a single writer and a single reader
	for (genvar g = 0; g < num_write_ports; g++) begin : g_group
		for (genvar k = 0; k < num_read_ports; k++) begin : g_bank
			bank_ram bank_ram_i (
				.clka (clka),
				.wr   (wp_vec[g]),
				.ra   (ra_vec[k]),
				.rd   (bank_rd[g][k])
			);
		end
	end

	// ========================================
	// ownership and read ports
	// ========================================

	lvt_control lvt_control_i (
		.clka   (clka),
		.arst_n (arst_n),
		.wp0    (wp0),
		.wp1    (wp1),
		.ra     (ra_vec),
		.sel    (sel_vec)
	);

	// each mux merges its two banks and forwards writes from the
	// cycle the address was presented
	for (genvar k = 0; k < num_read_ports; k++) begin : g_port
		read_port_mux read_port_mux_i (
			.clka   (clka),
			.arst_n (arst_n),
			.ra     (ra_vec[k]),
			.bank0  (bank_rd[0][k]),
			.bank1  (bank_rd[1][k]),
			.sel    (sel_vec[k]),
			.wp0    (wp0),
			.wp1    (wp1),
			.rd     (rd_vec[k])
		);
	end

endmodule

//--- src/regfile_pkg.sv
package regfile_pkg;

	// ========================================
	// geometry of the register file
	// ========================================

	localparam int num_lanes       = 9;
	localparam int byte_width      = 8;
	localparam int data_width      = 65;
	localparam int idx_width       = 5;
	localparam int ctx_width       = 2;
	localparam int addr_width      = ctx_width + idx_width;
	localparam int num_regs        = 128;
	localparam int num_read_ports  = 6;
	localparam int num_write_ports = 2;

	// the tag lane is the last lane and holds only the top bit of a register
	localparam int tag_lane = num_lanes - 1;
	localparam int tag_bit  = data_width - 1;

	typedef logic [data_width-1:0] reg_data_t;

	// low idx_width bits select the register, high bits the context
	typedef logic [addr_width-1:0] reg_addr_t;

	typedef logic [num_lanes-1:0] lane_en_t;

	// one bit per lane, 0 names the bank of write port 0 and 1 that of port 1
	typedef logic [num_lanes-1:0] lane_sel_t;

	typedef struct packed {
		logic      wr;
		reg_addr_t wa;
		lane_en_t  we;
		reg_data_t wd;
	} write_req_t;

	// expands one enable bit per lane into one mask bit per data bit
	function automatic reg_data_t lane_mask(lane_en_t en);
		reg_data_t m;
		for (int l = 0; l < tag_lane; l++) begin
			m[l*byte_width +: byte_width] = {byte_width{en[l]}};
		end
		m[tag_bit] = en[tag_lane];
		return m;
	endfunction

endpackage
